// File: sim.f
source/result_link_pkg.sv
source/uart_tx.sv
source/result_sender.sv
source/result_link_top.sv
test/result_link_assertions.sv
test/result_link_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= result_link_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := all tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: test/result_link_tb.sv
`timescale 1ns/1ps

module result_link_tb;

    logic                          clk = 1'b0;
    logic                          rst_n;
    result_link_pkg::result_word_u model_result;
    logic                          uart_txd;

    logic [9:0]  rx_q[$];           // stop, data, start as seen on the line
    logic [7:0]  exp_q[$];          // bytes predicted from the result words
    logic [31:0] rng_state;
    int          errors = 0;
    int          checked = 0;
    int          decoded_total = 0;
    logic        line_prev = 1'b1;

    result_link_top uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .model_result (model_result),
        .uart_txd     (uart_txd)
    );

    always #50 clk = ~clk;  // 100 ns

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // score n sits in bits 8n+7..8n of the word
    function automatic logic [7:0] expected_byte(input result_link_pkg::result_word_u word,
                                                 input int index);
        return word.raw[8*index +: 8];
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                               input string message);
        if (got !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s, got %0h expected %0h",
                     $time, message, got, expected);
        end
    endtask

    task automatic draw_word(output result_link_pkg::result_word_u word);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        word.raw = '0;
        while (word.raw == '0) begin  // zero means no result, draw again
            rng_state = xorshift32(rng_state);
            a = rng_state;
            rng_state = xorshift32(rng_state);
            b = rng_state;
            rng_state = xorshift32(rng_state);
            c = rng_state;
            word.raw = {a[15:0], b, c};
        end
    endtask

    task automatic expect_frame(input result_link_pkg::result_word_u word,
                                input int first, input int last);
        for (int i = first; i <= last; i++) begin
            exp_q.push_back(expected_byte(word, i));
        end
    endtask

    // hold a word on the input for a number of cycles
    task automatic drive_word(input result_link_pkg::result_word_u word, input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #1;
            model_result = word;
        end
    endtask

    task automatic clear_input();
        @(posedge clk);
        #1;
        model_result = '0;
    endtask

    task automatic wait_bytes(input int target, input string what);
        int cycles;
        int limit;
        cycles = 0;
        limit = (target - decoded_total + 1) * 11 * result_link_pkg::baud_div;
        while (decoded_total < target && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (decoded_total < target) begin
            errors++;
            $display("timeout: no start bit arrived in time for %s, %0d of %0d bytes decoded",
                     what, decoded_total, target);
        end
    endtask

    task automatic wait_quiet(input string what);
        int quiet;
        int cycles;
        int limit;
        quiet = 0;
        cycles = 0;
        limit = 2 * result_link_pkg::score_count * 11 * result_link_pkg::baud_div;
        while (quiet < 3 * result_link_pkg::baud_div && cycles < limit) begin
            @(negedge clk);
            cycles++;
            if (uart_txd === 1'b1) begin
                quiet++;
            end else begin
                quiet = 0;
            end
        end
        if (quiet < 3 * result_link_pkg::baud_div) begin
            errors++;
            $display("timeout: the serial line never went quiet after %s", what);
        end
    endtask

    // sample each bit in its middle, txd moves on the rising edge
    always begin : line_decoder
        logic [9:0] rx_frame;
        @(negedge clk);
        if (rst_n && line_prev && uart_txd === 1'b0) begin
            repeat (result_link_pkg::baud_div / 2) @(negedge clk);
            rx_frame[0] = uart_txd;
            for (int i = 1; i < 10; i++) begin
                repeat (result_link_pkg::baud_div) @(negedge clk);
                rx_frame[i] = uart_txd;
            end
            rx_q.push_back(rx_frame);
            decoded_total++;
        end
        line_prev = uart_txd;
    end

    always @(negedge clk) begin : compare_bytes
        logic [9:0] got;
        if (rx_q.size() > 0) begin
            got = rx_q.pop_front();
            check_value(32'(got[0]), 32'd0, $sformatf("start bit of byte %0d", checked));
            check_value(32'(got[9]), 32'd1, $sformatf("stop bit of byte %0d", checked));
            if (exp_q.size() == 0) begin
                errors++;
                $display("unexpected extra byte %02h received at %0t ns", got[8:1], $time);
            end else begin
                check_value(32'(got[8:1]), 32'(exp_q.pop_front()),
                            $sformatf("data of byte %0d", checked));
            end
            checked++;
        end
    end

    initial begin : run_tests
        result_link_pkg::result_word_u word_a;
        result_link_pkg::result_word_u word_b;
        result_link_pkg::result_word_u word_c;
        int base;
        int low_cycles;
        int assert_fails;
        rst_n = 1'b0;
        model_result = '0;
        rng_state = 32'h91af_d13e;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // idle after reset
        low_cycles = 0;
        repeat (2000) begin
            @(negedge clk);
            if (uart_txd !== 1'b1) begin
                low_cycles++;
            end
        end
        check_value(32'(low_cycles), 32'd0, "idle line went low after reset");
        check_value(32'(decoded_total), 32'd0, "bytes decoded with no result");

        // one-cycle result, distinct scores
        word_a.raw = 80'h5a_09_08_07_06_05_04_03_02_a5;
        expect_frame(word_a, 0, 9);
        base = decoded_total;
        drive_word(word_a, 1);
        clear_input();
        wait_bytes(base + 10, "a one-cycle result");
        wait_quiet("a one-cycle result");

        // held words, only the last one is sent
        draw_word(word_a);
        draw_word(word_b);
        draw_word(word_c);
        expect_frame(word_c, 0, 9);
        base = decoded_total;
        drive_word(word_a, 3);
        drive_word(word_b, 4);
        drive_word(word_c, 2);
        clear_input();
        wait_bytes(base + 10, "a held result");
        wait_quiet("a held result");

        // new word during byte 4 of the old frame
        draw_word(word_a);
        draw_word(word_b);
        expect_frame(word_a, 0, 4);
        expect_frame(word_b, 0, 9);
        base = decoded_total;
        drive_word(word_a, 1);
        clear_input();
        wait_bytes(base + 4, "the first bytes of the old frame");
        repeat (2 * result_link_pkg::baud_div) @(posedge clk);  // well inside byte 4
        drive_word(word_b, 1);
        clear_input();
        wait_bytes(base + 15, "the restarted frame");
        wait_quiet("the restarted frame");

        for (int n = 0; n < 8; n++) begin
            draw_word(word_a);
            expect_frame(word_a, 0, 9);
            base = decoded_total;
            drive_word(word_a, 1);
            clear_input();
            wait_bytes(base + 10, $sformatf("random result %0d", n));
            wait_quiet($sformatf("random result %0d", n));
        end

        repeat (10) @(negedge clk);
        check_value(32'(exp_q.size()), 32'd0, "expected bytes never arrived");
        assert_fails = uut.u_result_sender.u_uart_tx.u_link_assertions.en_fail_count
                     + uut.u_result_sender.u_uart_tx.u_link_assertions.idle_fail_count
                     + uut.u_result_sender.u_uart_tx.u_link_assertions.len_fail_count;
        $display("%0d bytes checked, %0d errors, %0d assertion failures",
                 checked, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: test/result_link_assertions.sv
`timescale 1ns/1ps

module result_link_assertions (
    input logic                     clk,
    input logic                     rst_n,
    input result_link_pkg::tx_req_t tx_req,
    input logic                     busy,
    input logic                     txd
);

    int unsigned busy_len;  // high cycles of the current frame
    int unsigned en_fail_count   = 0;
    int unsigned idle_fail_count = 0;
    int unsigned len_fail_count  = 0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_len <= 0;
        end else if (busy) begin
            busy_len <= busy_len + 1;
        end else begin
            busy_len <= 0;
        end
    end

    en_only_idle: assert property (@(posedge clk) disable iff (!rst_n)
        tx_req.en |-> !busy)
        else begin
            en_fail_count = en_fail_count + 1;
            $error("start strobe while the transmitter was busy");
        end

    // line stays at mark between frames
    idle_line_high: assert property (@(posedge clk) disable iff (!rst_n)
        !busy |-> txd)
        else begin
            idle_fail_count = idle_fail_count + 1;
            $error("txd low while the transmitter was idle");
        end

    frame_length: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(busy) |-> (busy_len == result_link_pkg::frame_bits * result_link_pkg::baud_div))
        else begin
            len_fail_count = len_fail_count + 1;
            $error("busy lasted %0d cycles", $sampled(busy_len));
        end

endmodule

bind uart_tx result_link_assertions u_link_assertions (
    .clk    (clk),
    .rst_n  (rst_n),
    .tx_req (tx_req),
    .busy   (busy),
    .txd    (txd)
);

// File: source/result_link_top.sv
`timescale 1ns/1ps

module result_link_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  result_link_pkg::result_word_u model_result,
    output logic                          uart_txd
);

    // serial line to the host
    logic txd;

    result_sender u_result_sender (
        .clk          (clk),
        .rst_n        (rst_n),
        .model_result (model_result),
        .uart_txd     (txd)
    );

    assign uart_txd = txd;

endmodule

// File: source/result_sender.sv
`timescale 1ns/1ps

module result_sender (
    input  logic                          clk,
    input  logic                          rst_n,
    input  result_link_pkg::result_word_u model_result,
    output logic                          uart_txd
);

    result_link_pkg::result_word_u          result_hold;  // last nonzero word
    logic                                   result_vld;
    result_link_pkg::tx_req_t               tx_req;
    logic                                   tx_busy;
    logic                                   busy_d0;
    logic                                   busy_d1;
    logic                                   busy_negedge;
    logic                                   line_idle;
    logic [result_link_pkg::byte_cnt_w-1:0] cnt;  // next score is cnt-1
    logic                                   cnt_active;
    logic                                   issue;

    uart_tx u_uart_tx (
        .clk    (clk),
        .rst_n  (rst_n),
        .tx_req (tx_req),
        .busy   (tx_busy),
        .txd    (uart_txd)
    );

    // keep the word while the classifier presents it
    always_ff @(posedge clk) begin
        if (model_result.raw != '0) begin
            result_hold <= model_result;
        end
    end

    // high for as long as a result is on the input, one cycle late
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_vld <= 1'b0;
        end else begin
            result_vld <= (model_result.raw != '0);
        end
    end

    // two-stage busy delay
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_d0 <= 1'b0;
            busy_d1 <= 1'b0;
        end else begin
            busy_d0 <= tx_busy;
            busy_d1 <= busy_d0;
        end
    end

    assign busy_negedge = busy_d1 && !busy_d0;  // byte done, 2 cycles on

    // nothing in flight and no edge still travelling through the delay
    assign line_idle = !tx_busy && !busy_d0 && !busy_d1 && !tx_req.en;

    assign cnt_active = (cnt >= result_link_pkg::byte_first)
                     && (cnt <= result_link_pkg::byte_last);

    // score 0 goes once the line is free, the rest follow each byte
    assign issue = cnt_active
                && (busy_negedge || (cnt == result_link_pkg::byte_first && line_idle));

    // byte sequencer
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt    <= result_link_pkg::byte_park;
            tx_req <= '0;
        end else begin
            tx_req.en <= 1'b0;
            if (result_vld) begin
                cnt <= result_link_pkg::byte_first;  // (re)start from score 0
            end else if (issue) begin
                tx_req.en   <= 1'b1;
                tx_req.data <= result_hold.scores[cnt - 1'b1];
                if (cnt == result_link_pkg::byte_last) begin
                    cnt <= result_link_pkg::byte_park;  // frame done
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

endmodule

// File: source/uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
    input  logic                     clk,
    input  logic                     rst_n,
    input  result_link_pkg::tx_req_t tx_req,
    output logic                     busy,
    output logic                     txd
);

    logic [result_link_pkg::frame_bits-1:0] frame;     // stop, data, start
    logic [result_link_pkg::baud_cnt_w-1:0] baud_cnt;  // cycles within the bit
    logic [result_link_pkg::bit_cnt_w-1:0]  bit_cnt;   // bit now on the line
    logic                                   start;
    logic                                   bit_end;
    logic                                   frame_end;

    // a strobe while busy is ignored
    assign start = tx_req.en && !busy;

    // last cycle of the current bit
    assign bit_end = busy && (baud_cnt == result_link_pkg::baud_last);

    // stop bit finishing
    assign frame_end = bit_end && (bit_cnt == result_link_pkg::bit_last);

    // line control
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            txd      <= 1'b1;  // line idles high
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else if (start) begin
            busy     <= 1'b1;
            txd      <= 1'b0;  // start bit from the next cycle
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else if (busy) begin
            if (frame_end) begin
                busy     <= 1'b0;
                txd      <= 1'b1;
                baud_cnt <= '0;
                bit_cnt  <= '0;
            end else if (bit_end) begin
                baud_cnt <= '0;
                bit_cnt  <= bit_cnt + 1'b1;
                txd      <= frame[1];  // next bit, lsb first
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end
        end
    end

    // shift frame, frame[0] is the bit on the line
    always_ff @(posedge clk) begin
        if (start) begin
            frame <= {1'b1, tx_req.data, 1'b0};
        end else if (bit_end) begin
            frame <= {1'b1, frame[result_link_pkg::frame_bits-1:1]};
        end
    end

endmodule

// File: source/result_link_pkg.sv
package result_link_pkg;

    // system timing
    localparam int unsigned clk_freq    = 50_000_000;
    localparam int unsigned uart_bps    = 115_200;
    localparam int unsigned baud_div    = clk_freq / uart_bps;  // 434 cycles per bit
    localparam int unsigned score_count = 10;

    // 8N1: start, eight data bits, stop
    localparam int unsigned frame_bits = 10;

    localparam int unsigned baud_cnt_w = $clog2(baud_div);
    localparam int unsigned bit_cnt_w  = $clog2(frame_bits);
    localparam int unsigned byte_cnt_w = $clog2(score_count + 1);  // 1..score_count and park

    localparam logic [baud_cnt_w-1:0] baud_last  = baud_cnt_w'(baud_div - 1);
    localparam logic [bit_cnt_w-1:0]  bit_last   = bit_cnt_w'(frame_bits - 1);
    localparam logic [byte_cnt_w-1:0] byte_first = byte_cnt_w'(1);
    localparam logic [byte_cnt_w-1:0] byte_last  = byte_cnt_w'(score_count);
    localparam logic [byte_cnt_w-1:0] byte_park  = '1;  // outside 1..score_count

    // one classifier result, seen whole or as bytes
    typedef union packed {
        logic [score_count*8-1:0]      raw;
        logic [score_count-1:0][7:0]   scores;  // scores[0] is the low byte
    } result_word_u;

    // transmit request into the uart
    typedef struct packed {
        logic       en;    // one-cycle start strobe
        logic [7:0] data;
    } tx_req_t;

endpackage
